// File: rtl/board_pkg.sv
/* Shared widths and timing constants for the board glue. RTC divider assumes a 50 MHz soc_clk,
   and the fan frame length is fixed at synthesis time. */

`default_nettype none

package board_pkg;

  //////////////////////////////
  // Real-time clock
  //////////////////////////////

  // soc_clk cycles per RTC half period, 50 MHz / 50 = 1 MHz
  localparam int unsigned RTC_HALF_PERIOD = 25;
  localparam int unsigned RTC_CNT_W       = 5;

  typedef logic [RTC_CNT_W-1:0] rtc_cnt_t;

  //////////////////////////////
  // Fan PWM
  //////////////////////////////

  // Duty setting in sixteenths of a frame
  localparam int unsigned FAN_SETTING_W   = 4;
  localparam int unsigned FAN_FRAME_SLOTS = 16;
  // Frame is FAN_FRAME_SLOTS * FAN_SLOT_CYCLES = 64 cycles
  localparam int unsigned FAN_SLOT_CYCLES = 4;

  typedef logic [FAN_SETTING_W-1:0]            fan_setting_t;
  typedef logic [$clog2(FAN_SLOT_CYCLES)-1:0]  fan_slot_cnt_t;

  //////////////////////////////
  // SPI host pins
  //////////////////////////////

  localparam int unsigned SPI_NUM_CS = 2;
  localparam int unsigned SPI_NUM_SD = 4;

  typedef logic [SPI_NUM_CS-1:0] spi_cs_t;
  typedef logic [SPI_NUM_SD-1:0] spi_sd_t;

endpackage

`default_nettype wire

// File: rtl/rtc_clk_div.sv
/* Free-running RTC square wave, soc_clk divided by 2 * RTC_HALF_PERIOD.
   Expects a reset already synchronized to soc_clk. */

`timescale 1ns/10ps
`default_nettype none

module rtc_clk_div (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  import board_pkg::*;

  rtc_cnt_t cnt_q;
  logic     wrap;
  logic     rtc_q;

  // Last cycle of a half period
  assign wrap = (cnt_q == rtc_cnt_t'(RTC_HALF_PERIOD - 1));

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (wrap) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Toggle once per half period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_q <= 1'b0;
    end else if (wrap) begin
      rtc_q <= ~rtc_q;
    end
  end

  assign rtc_o = rtc_q;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Counter must never run past the wrap point
  a_cnt_in_range : assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    cnt_q <= rtc_cnt_t'(RTC_HALF_PERIOD - 1)
  ) else $error("rtc_clk_div: counter out of range 0x%0h", cnt_q);

endmodule

`default_nettype wire

// File: rtl/fan_pwm_ctrl.sv
/* Fan PWM with duty in sixteenths of a 64-cycle frame. Switch changes take effect
   only at a frame boundary, so the output lags a new setting by up to two frames. */

`timescale 1ns/10ps
`default_nettype none

module fan_pwm_ctrl (
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  board_pkg::fan_setting_t fan_sw_i,
  output logic                    fan_pwm_o
);

  import board_pkg::*;

  fan_setting_t sw_meta_q;
  fan_setting_t sw_sync_q;
  fan_setting_t setting_q;

  fan_slot_cnt_t presc_q;
  logic [$clog2(FAN_FRAME_SLOTS)-1:0] slot_q;

  logic slot_end;
  logic frame_end;
  logic pwm_q;

  //////////////////////////////
  // Switch synchronizer
  //////////////////////////////

  // Board switches are asynchronous to soc_clk
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sw_meta_q <= '0;
      sw_sync_q <= '0;
    end else begin
      sw_meta_q <= fan_sw_i;
      sw_sync_q <= sw_meta_q;
    end
  end

  //////////////////////////////
  // Slot and frame counters
  //////////////////////////////

  assign slot_end  = (presc_q == fan_slot_cnt_t'(FAN_SLOT_CYCLES - 1));
  assign frame_end = slot_end && (slot_q == ($bits(slot_q))'(FAN_FRAME_SLOTS - 1));

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_q <= '0;
    end else if (slot_end) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + 1'b1;
    end
  end

  // One step per slot, wraps to zero at the end of a frame
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_q <= '0;
    end else if (frame_end) begin
      slot_q <= '0;
    end else if (slot_end) begin
      slot_q <= slot_q + 1'b1;
    end
  end

  // Setting is frozen for a whole frame
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      setting_q <= '0;
    end else if (frame_end) begin
      setting_q <= sw_sync_q;
    end
  end

  //////////////////////////////
  // Output
  //////////////////////////////

  // High for the first setting_q slots, one cycle behind the slot counter
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (slot_q < setting_q);
    end
  end

  assign fan_pwm_o = pwm_q;

  // Output may not leak high across a frame boundary into a zero setting
  a_off_when_zero : assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    (setting_q == '0) |-> !fan_pwm_o
  ) else $error("fan_pwm_ctrl: fan_pwm_o high with zero setting");

endmodule

`default_nettype wire

// File: rtl/board_glue_top.sv
/* Board glue around the SoC: reset synchronizer, RTC divider, fan PWM and SD-card SPI pins.
   SD reset, DAT1/DAT2 tie-offs and pad buffers are left to the board constraints. */

`timescale 1ns/10ps
`default_nettype none

module board_glue_top (
  input  logic                    soc_clk,
  input  logic                    rst_n,

  // Fan control
  input  board_pkg::fan_setting_t fan_sw_i,
  output logic                    fan_pwm_o,

  // Real-time clock to the SoC
  output logic                    rtc_o,

  // SPI host side of the SoC
  input  logic                    spih_sck_i,
  input  logic                    spih_sck_en_i,
  input  board_pkg::spi_cs_t      spih_csb_i,
  input  board_pkg::spi_cs_t      spih_csb_en_i,
  input  board_pkg::spi_sd_t      spih_sd_i,
  input  board_pkg::spi_sd_t      spih_sd_en_i,
  output board_pkg::spi_sd_t      spih_sd_o,

  // SD-card pins
  output logic                    sd_sclk_o,
  output logic                    sd_cs_o,
  output logic                    sd_cmd_o,
  input  logic                    sd_dat0_i
);

  import board_pkg::*;

  logic [1:0] rst_sync_q;
  logic       soc_rst_n;
  spi_sd_t    miso_lanes;

  //////////////////////////////
  // Reset synchronizer
  //////////////////////////////

  // Asserts at once, releases two soc_clk edges after rst_n rises
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign soc_rst_n = rst_sync_q[1];

  //////////////////////////////
  // RTC divider
  //////////////////////////////

  rtc_clk_div i_rtc_clk_div (
    .soc_clk ( soc_clk   ),
    .rst_n   ( soc_rst_n ),
    .rtc_o   ( rtc_o     )
  );

  //////////////////////////////
  // Fan control
  //////////////////////////////

  fan_pwm_ctrl i_fan_pwm_ctrl (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( soc_rst_n ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

  //////////////////////////////
  // SD-card SPI pins
  //////////////////////////////

  // Every SD pin idles high while its enable is off

  // SCK to SD CLK
  assign sd_sclk_o = spih_sck_en_i    ? spih_sck_i    : 1'b1;

  // Chip select 0 to SD DAT3
  assign sd_cs_o   = spih_csb_en_i[0] ? spih_csb_i[0] : 1'b1;

  // MOSI on lane 0 to SD CMD
  assign sd_cmd_o  = spih_sd_en_i[0]  ? spih_sd_i[0]  : 1'b1;

  // MISO from SD DAT0 returns on lane 1, other lanes read zero
  always_comb begin
    miso_lanes    = '0;
    miso_lanes[1] = sd_dat0_i;
  end

  assign spih_sd_o = miso_lanes;

  // CS1 and lanes 1 to 3 have no SD pin
  // (spih_csb_i[1], spih_sd_i[3:1] and their enables stay unconnected)

endmodule

`default_nettype wire

// File: tests/tb_model.svh
/* Reference model for the board glue testbench. Included inside the testbench module,
   after the board_pkg import. */

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32-bit LCG step, the usual C library constants
function automatic int unsigned lcg_next(input int unsigned state);
  return state * 32'd1103515245 + 32'd12345;
endfunction

// High cycles per frame, one slot of FAN_SLOT_CYCLES per sixteenth
function automatic int unsigned expected_pwm_highs(input fan_setting_t setting);
  int unsigned slots;
  slots = setting;
  return slots * FAN_SLOT_CYCLES;
endfunction

// SD pin follows its source when enabled, idles high otherwise
function automatic logic expected_sd_pin(input logic src, input logic en);
  if (en) begin
    return src;
  end
  return 1'b1;
endfunction

// MISO comes back on lane 1 only
function automatic spi_sd_t expected_miso_lanes(input logic dat0);
  spi_sd_t lanes;
  lanes    = '0;
  lanes[1] = dat0;
  return lanes;
endfunction

`endif

// File: tests/tb_board_glue.sv
/* Self-checking testbench for board_glue_top. Registered outputs are sampled on the
   falling edge, SD pins just before the rising edge. */

`timescale 1ns/10ps
`default_nettype none

module tb_board_glue;

  import board_pkg::*;

  `include "tb_model.svh"

  localparam int unsigned SEED         = 57457;
  localparam int unsigned RTC_EDGES    = 20;
  localparam int unsigned FAN_TRIALS   = 12;
  localparam int unsigned SD_VECTORS   = 200;
  localparam int unsigned EDGE_LIMIT   = 4 * RTC_HALF_PERIOD;
  localparam int unsigned FRAME_CYCLES = FAN_FRAME_SLOTS * FAN_SLOT_CYCLES;

  logic         soc_clk;
  logic         rst_n;
  fan_setting_t fan_sw_i;
  logic         fan_pwm_o;
  logic         rtc_o;
  logic         spih_sck_i;
  logic         spih_sck_en_i;
  spi_cs_t      spih_csb_i;
  spi_cs_t      spih_csb_en_i;
  spi_sd_t      spih_sd_i;
  spi_sd_t      spih_sd_en_i;
  spi_sd_t      spih_sd_o;
  logic         sd_sclk_o;
  logic         sd_cs_o;
  logic         sd_cmd_o;
  logic         sd_dat0_i;

  int unsigned lcg_state;
  int unsigned value_errs;
  int unsigned timeout_errs;

  board_glue_top dut_i (
    .soc_clk       ( soc_clk       ),
    .rst_n         ( rst_n         ),
    .fan_sw_i      ( fan_sw_i      ),
    .fan_pwm_o     ( fan_pwm_o     ),
    .rtc_o         ( rtc_o         ),
    .spih_sck_i    ( spih_sck_i    ),
    .spih_sck_en_i ( spih_sck_en_i ),
    .spih_csb_i    ( spih_csb_i    ),
    .spih_csb_en_i ( spih_csb_en_i ),
    .spih_sd_i     ( spih_sd_i     ),
    .spih_sd_en_i  ( spih_sd_en_i  ),
    .spih_sd_o     ( spih_sd_o     ),
    .sd_sclk_o     ( sd_sclk_o     ),
    .sd_cs_o       ( sd_cs_o       ),
    .sd_cmd_o      ( sd_cmd_o      ),
    .sd_dat0_i     ( sd_dat0_i     )
  );

  // 100 ns period
  always #50 soc_clk = ~soc_clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Upper half of the LCG state, the low bits repeat too soon
  function automatic int unsigned next_random();
    lcg_state = lcg_next(lcg_state);
    return lcg_state >> 16;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      value_errs++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s at %0t", what, $time);
    timeout_errs++;
  endtask

  // Falling edges until rtc_o changes, bounded by EDGE_LIMIT
  task automatic wait_rtc_toggle(output int unsigned cycles, output bit ok);
    logic prev;
    prev   = rtc_o;
    cycles = 0;
    do begin
      @(negedge soc_clk);
      cycles++;
    end while (rtc_o === prev && cycles < EDGE_LIMIT);
    ok = (rtc_o !== prev);
  endtask

  //////////////////////////////
  // Test phases
  //////////////////////////////

  task automatic apply_reset();
    repeat (8) begin
      @(negedge soc_clk);
      check_value("rtc_o", rtc_o, 1'b0);
      check_value("fan_pwm_o", fan_pwm_o, 1'b0);
    end
    rst_n = 1'b1;
    @(negedge soc_clk);
    check_value("rtc_o", rtc_o, 1'b0);
    check_value("fan_pwm_o", fan_pwm_o, 1'b0);
  endtask

  task automatic check_rtc_period();
    int unsigned cycles;
    int unsigned edges;
    bit          ok;
    // First toggle only aligns the measurement
    wait_rtc_toggle(cycles, ok);
    if (!ok) begin
      report_timeout("rtc_o never toggled after reset");
      return;
    end
    for (edges = 0; edges < RTC_EDGES; edges++) begin
      wait_rtc_toggle(cycles, ok);
      if (!ok) begin
        report_timeout("rtc_o stopped toggling");
        return;
      end
      check_value("rtc_o half period", cycles, RTC_HALF_PERIOD);
    end
  endtask

  task automatic check_fan_duty();
    fan_setting_t setting;
    int unsigned  trial;
    int unsigned  highs;
    for (trial = 0; trial < FAN_TRIALS; trial++) begin
      // Both extremes first, then random settings
      if (trial == 0) begin
        setting = '0;
      end else if (trial == 1) begin
        setting = '1;
      end else begin
        setting = fan_setting_t'(next_random());
      end
      @(negedge soc_clk);
      fan_sw_i = setting;
      repeat (3 * FRAME_CYCLES) @(negedge soc_clk);
      highs = 0;
      repeat (FRAME_CYCLES) begin
        @(negedge soc_clk);
        if (fan_pwm_o === 1'b1) begin
          highs++;
        end
      end
      check_value("fan_pwm_o high cycles", highs, expected_pwm_highs(setting));
    end
  endtask

  task automatic check_sd_pins();
    int unsigned r;
    int unsigned n;
    for (n = 0; n < SD_VECTORS; n++) begin
      @(negedge soc_clk);
      r             = next_random();
      spih_sck_i    = r[0];
      spih_sck_en_i = r[1];
      spih_csb_i    = r[3:2];
      spih_csb_en_i = r[5:4];
      spih_sd_i     = r[9:6];
      spih_sd_en_i  = r[13:10];
      sd_dat0_i     = r[14];
      // Just before the next rising edge
      #40;
      check_value("sd_sclk_o", sd_sclk_o, expected_sd_pin(spih_sck_i, spih_sck_en_i));
      check_value("sd_cs_o", sd_cs_o, expected_sd_pin(spih_csb_i[0], spih_csb_en_i[0]));
      check_value("sd_cmd_o", sd_cmd_o, expected_sd_pin(spih_sd_i[0], spih_sd_en_i[0]));
      check_value("spih_sd_o", spih_sd_o, expected_miso_lanes(sd_dat0_i));
    end
  endtask

  initial begin
    soc_clk       = 1'b0;
    rst_n         = 1'b0;
    fan_sw_i      = '0;
    spih_sck_i    = 1'b0;
    spih_sck_en_i = 1'b0;
    spih_csb_i    = '1;
    spih_csb_en_i = '0;
    spih_sd_i     = '0;
    spih_sd_en_i  = '0;
    sd_dat0_i     = 1'b0;
    lcg_state     = SEED;
    value_errs    = 0;
    timeout_errs  = 0;

    apply_reset();
    check_rtc_period();
    check_fan_duty();
    check_sd_pins();

    $display("Errors: %0d wrong values, %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+tests
rtl/board_pkg.sv
rtl/rtc_clk_div.sv
rtl/fan_pwm_ctrl.sv
rtl/board_glue_top.sv
tests/tb_board_glue.sv

// File: Makefile
# Verilator simulation of the board glue

TOP := tb_board_glue
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, verdict taken from $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "test: failure reported in $(LOG)"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "test: run ended without a verdict in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
